// ==== flist.f ====
common/spi_pkg.sv
common/accel_pkg.sv
spi/spi_byte_engine.sv
source/accel_sequencer.sv
source/sample_packer.sv
source/accel_top.sv
verification/accel_checker.sv
verification/accel_tb.sv

// ==== Bender.yml ====
package:
  name: accel_spi

sources:
  - common/spi_pkg.sv
  - common/accel_pkg.sv
  - spi/spi_byte_engine.sv
  - source/accel_sequencer.sv
  - source/sample_packer.sv
  - source/accel_top.sv
  - target: simulation
    files:
      - verification/accel_checker.sv
      - verification/accel_tb.sv

// ==== verification/accel_tb.sv ====
`default_nettype none

// Testbench for the accelerometer SPI master with a simple sensor model
module accel_tb import spi_pkg::*, accel_pkg::*; ();

	localparam int SCLK_DIV             = 4;
	localparam int POWERUP_CYCLES       = 100;
	localparam int MEAS_WAIT_CYCLES     = 200;
	localparam int READ_INTERVAL_CYCLES = 150;
	localparam int RESET_CYCLES         = 16;
	localparam int NUM_SAMPLES          = 8;

	localparam int BURST_CYCLES = 8 * 8 * SCLK_DIV + 2;	// Eight bytes plus framing
	localparam int CONFIG_CYCLES = 3 * 8 * SCLK_DIV + 2;
	localparam int EXPECTED_CYCLES = RESET_CYCLES + POWERUP_CYCLES + MEAS_WAIT_CYCLES
		+ CONFIG_CYCLES + NUM_SAMPLES * (BURST_CYCLES + READ_INTERVAL_CYCLES);
	// Half again as long, rounded up to a whole thousand
	localparam int TIMEOUT_CYCLES = ((EXPECTED_CYCLES * 3 / 2) / 1000 + 1) * 1000;

	logic          iclk;
	logic          rst;
	logic          miso;
	spi_pins_t     spi;
	accel_sample_t sample_out;
	acl_fields_t   acl_data;
	logic          sample_valid;

	int test_pass_count;
	int test_fail_count;
	int error_count;
	int sample_count;
	int cycle_count;

	// Sensor model state
	int          seed = 32'h6a5cf289;
	int          rise_cnt = 0;
	logic        sensor_prev_sclk = 1'b0;
	logic        is_read = 1'b0;
	logic [15:0] cmd = '0;	// Instruction and address as seen on MOSI
	logic [47:0] stream = '0;	// Six data bytes, first one on top

	accel_top #(
		.SCLK_DIV            (SCLK_DIV),
		.POWERUP_CYCLES      (POWERUP_CYCLES),
		.MEAS_WAIT_CYCLES    (MEAS_WAIT_CYCLES),
		.READ_INTERVAL_CYCLES(READ_INTERVAL_CYCLES)
	) i_dut (
		.iclk        (iclk),
		.rst         (rst),
		.miso        (miso),
		.spi         (spi),
		.sample_out  (sample_out),
		.acl_data    (acl_data),
		.sample_valid(sample_valid)
	);

	accel_checker #(
		.READ_INTERVAL_CYCLES(READ_INTERVAL_CYCLES)
	) i_checker (
		.iclk           (iclk),
		.rst            (rst),
		.spi            (spi),
		.miso           (miso),
		.sample_out     (sample_out),
		.acl_data       (acl_data),
		.sample_valid   (sample_valid),
		.test_pass_count(test_pass_count),
		.test_fail_count(test_fail_count),
		.error_count    (error_count),
		.sample_count   (sample_count)
	);

	initial begin
		iclk = 1'b0;
		forever #2 iclk = ~iclk;
	end

	initial begin
		rst = 1'b1;
		miso = 1'b0;
		repeat (RESET_CYCLES) @(posedge iclk);
		@(negedge iclk);
		rst <= 1'b0;
	end

	// Sensor side, shifts MOSI on each SCLK rise and answers a burst read
	always @(negedge iclk) begin
		if (rst || spi.cs_n) begin
			rise_cnt = 0;
			cmd = '0;
			is_read = 1'b0;
			miso <= 1'b0;
		end else if (spi.sclk && !sensor_prev_sclk) begin
			rise_cnt++;
			if (rise_cnt <= 16)
				cmd = {cmd[14:0], spi.mosi};
			if (rise_cnt == 16 && cmd == 16'h0B0E) begin
				// Fresh data for every burst
				for (int i = 0; i < 6; i++)
					stream = {stream[39:0], 8'($random(seed))};
				is_read = 1'b1;
			end
			if (is_read && rise_cnt >= 16 && rise_cnt < 64)
				miso <= stream[63 - rise_cnt];	// MSB first, ready before the next rise
			else
				miso <= 1'b0;
		end
		sensor_prev_sclk = spi.sclk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge iclk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, only %0d of %0d samples arrived",
			cycle_count, sample_count, NUM_SAMPLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		wait (sample_count >= NUM_SAMPLES);
		@(posedge iclk);
		$display("Totals: %0d tests passed, %0d failed, %0d errors, %0d samples",
			test_pass_count, test_fail_count, error_count, sample_count);
		if (error_count == 0 && test_fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/accel_checker.sv ====
`default_nettype none

// Watches the SPI pins and the sample outputs of the accelerometer master
module accel_checker import spi_pkg::*, accel_pkg::*; #(
	parameter int READ_INTERVAL_CYCLES = 150
) (
	input  wire logic          iclk,
	input  wire logic          rst,
	input  wire spi_pins_t     spi,
	input  wire logic          miso,
	input  wire accel_sample_t sample_out,
	input  wire acl_fields_t   acl_data,
	input  wire logic          sample_valid,
	output int                 test_pass_count,
	output int                 test_fail_count,
	output int                 error_count,
	output int                 sample_count
);

	logic          prev_cs = 1'b1;
	logic          prev_sclk = 1'b0;
	logic          seen_frame = 1'b0;
	logic          valid_due = 1'b0;	// Sample expected at the next falling edge
	int            frames_done = 0;
	int            bit_cnt = 0;
	int            err_mark = 0;
	int            cycle = 0;
	int            last_end_cycle = 0;
	logic [63:0]   mosi_bits = '0;
	logic [63:0]   miso_bits = '0;
	accel_sample_t exp_sample;
	acl_fields_t   exp_fields;

	initial begin
		test_pass_count = 0;
		test_fail_count = 0;
		error_count = 0;
		sample_count = 0;
	end

	// Bytes come in bus order starting with x low
	// Every axis is sent low byte first
	function automatic void decode_burst(input logic [47:0] data,
		output accel_sample_t s, output acl_fields_t f);
		s.x = {data[39:32], data[47:40]};
		s.y = {data[23:16], data[31:24]};
		s.z = {data[7:0], data[15:8]};
		f.x = s.x[11:7];
		f.y = s.y[11:7];
		f.z = s.z[11:7];
	endfunction

	task automatic close_test(input string name);
		if (error_count == err_mark) begin
			test_pass_count++;
			$display("%-14s PASS", name);
		end else begin
			test_fail_count++;
			$display("%-14s FAIL (%0d errors)", name, error_count - err_mark);
		end
		err_mark = error_count;
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		error_count++;
	endtask

	// Pins and outputs taken mid-cycle on the falling edge
	always @(negedge iclk) begin
		cycle++;
		if (!seen_frame && ($isunknown(spi.cs_n) || (rst && spi.cs_n !== 1'b1)
			|| spi.sclk !== 1'b0 || sample_valid !== 1'b0))
			note_failure($sformatf("Bus not idle before the first frame at cycle %0d", cycle));

		if (valid_due) begin
			valid_due = 1'b0;
			if (sample_valid !== 1'b1) begin
				note_failure($sformatf("No sample_valid one cycle after frame %0d ended",
					frames_done - 1));
			end else begin
				sample_count++;
				check_value("sample_out.x", sample_out.x, exp_sample.x);
				check_value("sample_out.y", sample_out.y, exp_sample.y);
				check_value("sample_out.z", sample_out.z, exp_sample.z);
				check_value("acl_data", acl_data, exp_fields);
			end
			close_test($sformatf("read frame %0d", frames_done - 1));
		end else if (seen_frame && sample_valid !== 1'b0) begin
			note_failure($sformatf("Unexpected sample_valid pulse at cycle %0d", cycle));
		end

		// Chip select falls and a new frame begins
		if (spi.cs_n === 1'b0 && prev_cs === 1'b1) begin
			if (!seen_frame) begin
				close_test("reset state");
				seen_frame = 1'b1;
			end else if (frames_done == 1) begin
				close_test("config write");
			end else if (cycle - last_end_cycle < READ_INTERVAL_CYCLES) begin
				note_failure($sformatf("Read frames only %0d cycles apart",
					cycle - last_end_cycle));
			end
			bit_cnt = 0;
			mosi_bits = '0;
			miso_bits = '0;
		end

		if (spi.cs_n === 1'b0 && spi.sclk === 1'b1 && prev_sclk === 1'b0) begin
			mosi_bits = {mosi_bits[62:0], spi.mosi};
			miso_bits = {miso_bits[62:0], miso};
			bit_cnt++;
		end

		// Chip select rises at the end of the frame
		if (spi.cs_n === 1'b1 && prev_cs === 1'b0) begin
			if (frames_done == 0) begin
				if (bit_cnt != 24)
					note_failure($sformatf("Config frame carried %0d bits instead of 24", bit_cnt));
				check_value("mosi config bytes", mosi_bits[23:0], 24'h0A2D02);
			end else begin
				if (bit_cnt != 64)
					note_failure($sformatf("Read frame %0d carried %0d bits instead of 64",
						frames_done, bit_cnt));
				check_value("mosi read header", mosi_bits[63:48], 16'h0B0E);
				decode_burst(miso_bits[47:0], exp_sample, exp_fields);
				valid_due = 1'b1;
				last_end_cycle = cycle;
			end
			frames_done++;
		end

		prev_cs = spi.cs_n;
		prev_sclk = spi.sclk;
	end

endmodule

`default_nettype wire

// ==== source/accel_top.sv ====
`default_nettype none

// Accelerometer SPI master top level
module accel_top import spi_pkg::*, accel_pkg::*; #(
	parameter int SCLK_DIV             = 4,
	parameter int POWERUP_CYCLES       = 24000,	// 6 ms at 4 MHz
	parameter int MEAS_WAIT_CYCLES     = 160000,	// 40 ms to first valid data
	parameter int READ_INTERVAL_CYCLES = 40000	// 100 Hz polling
) (
	input  wire logic iclk,
	input  wire logic rst,
	input  wire logic miso,
	output spi_pins_t     spi,
	output accel_sample_t sample_out,
	output acl_fields_t   acl_data,
	output logic          sample_valid
);

	spi_req_t      req;
	spi_rsp_t      rsp;
	logic          ready;
	logic          cs_n;
	logic          sclk;
	logic          mosi;
	accel_sample_t sample;
	logic          sample_done;

	assign spi = '{sclk: sclk, mosi: mosi, cs_n: cs_n};

	accel_sequencer #(
		.POWERUP_CYCLES      (POWERUP_CYCLES),
		.MEAS_WAIT_CYCLES    (MEAS_WAIT_CYCLES),
		.READ_INTERVAL_CYCLES(READ_INTERVAL_CYCLES)
	) i_seq (
		.iclk       (iclk),
		.rst        (rst),
		.req        (req),
		.ready      (ready),
		.rsp        (rsp),
		.cs_n       (cs_n),
		.sample     (sample),
		.sample_done(sample_done)
	);

	spi_byte_engine #(
		.SCLK_DIV(SCLK_DIV)
	) i_engine (
		.iclk (iclk),
		.rst  (rst),
		.req  (req),
		.ready(ready),
		.rsp  (rsp),
		.miso (miso),
		.sclk (sclk),
		.mosi (mosi)
	);

	sample_packer i_packer (
		.iclk        (iclk),
		.rst         (rst),
		.sample      (sample),
		.sample_done (sample_done),
		.sample_out  (sample_out),
		.acl_data    (acl_data),
		.sample_valid(sample_valid)
	);

endmodule

`default_nettype wire

// ==== source/sample_packer.sv ====
`default_nettype none

// Output stage, holds the last sample and its 15-bit summary
module sample_packer import accel_pkg::*; (
	input  wire logic          iclk,
	input  wire logic          rst,
	input  wire accel_sample_t sample,
	input  wire logic          sample_done,
	output accel_sample_t      sample_out,
	output acl_fields_t        acl_data,
	output logic               sample_valid
);

	acl_fields_t fields;

	// Sign bit and four bits below it, x on top
	assign fields = '{
		x: sample.x[FIELD_MSB:FIELD_LSB],
		y: sample.y[FIELD_MSB:FIELD_LSB],
		z: sample.z[FIELD_MSB:FIELD_LSB]
	};

	always_ff @(posedge iclk) begin
		if (rst)
			sample_valid <= 1'b0;
		else
			sample_valid <= sample_done;	// One-cycle pulse
	end

	// Held until the next sample overwrites them
	always_ff @(posedge iclk) begin
		if (sample_done) begin
			sample_out <= sample;
			acl_data <= fields;
		end
	end

endmodule

`default_nettype wire

// ==== source/accel_sequencer.sv ====
`default_nettype none

// Bring-up and polling sequence for the accelerometer
// Power-up wait, mode write, measurement wait, then burst reads forever
module accel_sequencer import spi_pkg::*, accel_pkg::*; #(
	parameter int POWERUP_CYCLES       = 24000,
	parameter int MEAS_WAIT_CYCLES     = 160000,
	parameter int READ_INTERVAL_CYCLES = 40000
) (
	input  wire logic     iclk,
	input  wire logic     rst,
	output spi_req_t      req,
	input  wire logic     ready,
	input  wire spi_rsp_t rsp,
	output logic          cs_n,
	output accel_sample_t sample,
	output logic          sample_done
);

	localparam int WRITE_BYTES = 3;	// Instruction, address, value
	localparam int READ_BYTES  = 2 + 2 * AXIS_COUNT;

	typedef enum logic [2:0] {
		S_POWERUP,
		S_WRITE,
		S_MEAS_WAIT,
		S_READ,
		S_INTERVAL
	} state_t;

	state_t    state;
	logic [31:0] wait_cnt;
	logic [3:0]  byte_idx;	// Next byte for the engine
	logic [3:0]  burst_len;
	logic        in_flight;
	logic        lead;	// First cycle of a frame, cs_n low and no request yet
	logic        in_burst;
	logic        last_done;
	logic        req_valid;
	logic        accept;
	spi_byte_t   tx_byte;

	assign in_burst = (state == S_WRITE) || (state == S_READ);
	assign burst_len = (state == S_WRITE) ? 4'(WRITE_BYTES) : 4'(READ_BYTES);

	// Next request goes out in the same cycle as the previous done
	assign req_valid = in_burst && !lead && (byte_idx != burst_len)
		&& (!in_flight || rsp.done);
	assign req = '{valid: req_valid, tx_byte: tx_byte};
	assign accept = req_valid && ready;

	assign last_done = in_burst && rsp.done && (byte_idx == burst_len);

	always_comb begin
		if (state == S_WRITE) begin
			case (byte_idx)
				4'd0:    tx_byte = WRITE_INSTR;
				4'd1:    tx_byte = MODE_REG_ADDR;
				default: tx_byte = MODE_MEASURE;
			endcase
		end else begin
			case (byte_idx)
				4'd0:    tx_byte = READ_INSTR;
				4'd1:    tx_byte = XDATA_L_ADDR;
				default: tx_byte = 8'h00;	// Dummy while the sensor talks
			endcase
		end
	end

	always_ff @(posedge iclk) begin
		if (rst) begin
			state <= S_POWERUP;
			wait_cnt <= 32'(POWERUP_CYCLES - 1);
			byte_idx <= '0;
			in_flight <= 1'b0;
			lead <= 1'b0;
			cs_n <= 1'b1;
			sample_done <= 1'b0;
		end else begin
			sample_done <= 1'b0;
			lead <= 1'b0;
			if (accept) begin
				byte_idx <= byte_idx + 4'd1;
				in_flight <= 1'b1;
			end else if (rsp.done) begin
				in_flight <= 1'b0;
			end

			case (state)
				S_POWERUP, S_MEAS_WAIT, S_INTERVAL: begin
					if (wait_cnt == '0) begin
						// Open a frame, first request one cycle later
						state <= (state == S_POWERUP) ? S_WRITE : S_READ;
						cs_n <= 1'b0;
						lead <= 1'b1;
						byte_idx <= '0;
					end else begin
						wait_cnt <= wait_cnt - 32'd1;
					end
				end
				S_WRITE: begin
					if (last_done) begin
						state <= S_MEAS_WAIT;
						cs_n <= 1'b1;
						wait_cnt <= 32'(MEAS_WAIT_CYCLES - 1);
					end
				end
				S_READ: begin
					if (last_done) begin
						state <= S_INTERVAL;
						cs_n <= 1'b1;
						sample_done <= 1'b1;	// Same cycle as the cs_n rise
						wait_cnt <= 32'(READ_INTERVAL_CYCLES - 1);
					end
				end
				default: state <= S_POWERUP;
			endcase
		end
	end

	// byte_idx is already one past the byte that just finished
	always_ff @(posedge iclk) begin
		if (state == S_READ && rsp.done) begin
			case (byte_idx)
				4'd3:    sample.x[7:0]  <= rsp.rx_byte;
				4'd4:    sample.x[15:8] <= rsp.rx_byte;
				4'd5:    sample.y[7:0]  <= rsp.rx_byte;
				4'd6:    sample.y[15:8] <= rsp.rx_byte;
				4'd7:    sample.z[7:0]  <= rsp.rx_byte;
				4'd8:    sample.z[15:8] <= rsp.rx_byte;
				default: ;	// Instruction and address echo
			endcase
		end
	end

	// Chip select stays low from acceptance until the engine reports done
	a_cs_frame: assert property (@(posedge iclk) disable iff (rst)
		accept |-> !cs_n ##1 (!cs_n throughout rsp.done[->1]));

endmodule

`default_nettype wire

// ==== spi/spi_byte_engine.sv ====
`default_nettype none

// SPI mode 0 byte shifter
// Each bit lasts SCLK_DIV cycles, SCLK low in the first half and high in the second
module spi_byte_engine import spi_pkg::*; #(
	parameter int SCLK_DIV = 4	// Even, at least 4
) (
	input  wire logic     iclk,
	input  wire logic     rst,
	input  wire spi_req_t req,
	output logic          ready,
	output spi_rsp_t      rsp,
	input  wire logic     miso,
	output logic          sclk,
	output logic          mosi
);

	localparam int HALF = SCLK_DIV / 2;
	localparam int PW = $clog2(SCLK_DIV);

	logic [PW-1:0] phase;	// Position inside the current bit
	logic [2:0]    bit_idx;
	logic          busy;
	logic          done;
	spi_byte_t     shreg;	// Out at the MSB, in at the LSB

	assign ready = !busy;
	assign rsp = '{done: done, rx_byte: shreg};

	always_ff @(posedge iclk) begin
		if (rst) begin
			busy <= 1'b0;
			phase <= '0;
			bit_idx <= '0;
			sclk <= 1'b0;
			mosi <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				// Acceptance cycle counts as phase 0 of the MSB
				if (req.valid) begin
					busy <= 1'b1;
					phase <= PW'(1);
					bit_idx <= '0;
					mosi <= req.tx_byte[7];
				end
			end else if (phase == PW'(SCLK_DIV - 1)) begin
				phase <= '0;
				sclk <= 1'b0;	// Bit boundary
				if (bit_idx == 3'd7) begin
					busy <= 1'b0;
					done <= 1'b1;	// Ready again in the same cycle
					mosi <= 1'b0;
				end else begin
					bit_idx <= bit_idx + 3'd1;
					mosi <= shreg[7];	// Next bit goes out as the bit begins
				end
			end else begin
				phase <= phase + PW'(1);
				if (phase == PW'(HALF - 1))
					sclk <= 1'b1;
			end
		end
	end

	always_ff @(posedge iclk) begin
		if (!busy && req.valid)
			shreg <= req.tx_byte;
		else if (busy && phase == PW'(HALF - 1))
			shreg <= {shreg[6:0], miso};	// MISO taken on the SCLK rise
	end

	// SCLK idles low whenever a new byte may start
	a_sclk_idle: assert property (@(posedge iclk) disable iff (rst)
		ready |-> !sclk);

	// The requester keeps its byte up and unchanged until it is taken
	a_req_hold: assert property (@(posedge iclk) disable iff (rst)
		req.valid && !ready |=> req.valid && $stable(req.tx_byte));

endmodule

`default_nettype wire

// ==== common/accel_pkg.sv ====
`default_nettype none

// Accelerometer command set and sample formats
package accel_pkg;

	// Instruction codes
	localparam logic [7:0] WRITE_INSTR = 8'h0A;
	localparam logic [7:0] READ_INSTR  = 8'h0B;

	localparam logic [7:0] MODE_REG_ADDR = 8'h2D;	// Power control register
	localparam logic [7:0] MODE_MEASURE  = 8'h02;	// Measurement mode value

	// X low byte, the sensor steps through Y and Z from here
	localparam logic [7:0] XDATA_L_ADDR = 8'h0E;

	localparam int AXIS_COUNT = 3;

	// Slice of each axis kept in the summary, sign plus four bits
	localparam int FIELD_MSB = 11;
	localparam int FIELD_LSB = 7;

	typedef logic signed [15:0] axis_t;

	// Full sample, x in the upper bits
	typedef struct packed {
		axis_t x;
		axis_t y;
		axis_t z;
	} accel_sample_t;

	// 15-bit summary, 5 bits per axis
	typedef struct packed {
		logic [FIELD_MSB-FIELD_LSB:0] x;
		logic [FIELD_MSB-FIELD_LSB:0] y;
		logic [FIELD_MSB-FIELD_LSB:0] z;
	} acl_fields_t;

endpackage

`default_nettype wire

// ==== common/spi_pkg.sv ====
`default_nettype none

// Types shared by the SPI byte engine and its users
package spi_pkg;

	typedef logic [7:0] spi_byte_t;	// One byte on the wire

	// Pins driven by the master
	typedef struct packed {
		logic sclk;
		logic mosi;
		logic cs_n;	// Active low
	} spi_pins_t;

	// Byte request into the engine
	typedef struct packed {
		logic      valid;
		spi_byte_t tx_byte;	// Sent MSB first
	} spi_req_t;

	// Result of one finished byte
	typedef struct packed {
		logic      done;	// One-cycle pulse
		spi_byte_t rx_byte;
	} spi_rsp_t;

endpackage

`default_nettype wire
